/* hdl/simdPkg.sv */
// SIMD float unit definitions
package simdPkg;

	// register and opcode words as seen on the issue lanes
	typedef logic [8:0] cmdWord;
	typedef logic [8:0] ixtWord;
	typedef logic [63:0] regWord;

	// element formats
	typedef logic [31:0] spFloat;
	typedef logic [15:0] hpFloat;

	// fields inside the opcode and the extension word
	typedef logic [5:0] majorOp;
	typedef logic [1:0] fmtCode;
	typedef logic [3:0] opCode;

	// major opcode of a vector-float command, low six bits of cmd
	localparam majorOp ucmdFpuVec4 = 6'h2A;

	// element format, ixt bits 5..4
	localparam fmtCode ixtFmtSingle = 2'b00;
	localparam fmtCode ixtFmtHalf = 2'b01;

	// operation, ixt bits 3..0
	localparam opCode ixtOpAdd = 4'd0;
	localparam opCode ixtOpSub = 4'd1;
	localparam opCode ixtOpMul = 4'd2;

	// canonical quiet NaNs, payloads are never carried through
	localparam spFloat spQuietNan = 32'h7FC00000;
	localparam hpFloat hpQuietNan = 16'h7E00;

endpackage

/* hdl/fpLaneIf.sv */
// arithmetic lane bundle
`timescale 1ns/1ps

interface fpLaneIf import simdPkg::*;
();

	logic hold;
	spFloat srcA;
	spFloat srcB;
	// only the add lanes look at this
	logic isSub;
	spFloat result;

	modport unit (output hold, output srcA, output srcB, output isSub, input result);

	modport lane (input hold, input srcA, input srcB, input isSub, output result);

endinterface

/* hdl/halfToSingle.sv */
// half to single widening
`timescale 1ns/1ps

module halfToSingle import simdPkg::*;
(
	input hpFloat half,
	output spFloat single
);

	logic [4:0] expIn;
	logic [9:0] frac;
	logic [7:0] expOut;

	assign expIn = half[14:10];
	assign frac = half[9:0];

	// rebias from 15 to 127
	assign expOut = {3'b000, expIn} + 8'd112;

	always_comb
	begin
		if (expIn == 5'd0)
			// subnormals and zeros both land on signed zero
			single = {half[15], 31'd0};
		else if (expIn == 5'h1F)
			// inf stays inf, NaN stays NaN
			single = {half[15], 8'hFF, frac, 13'd0};
		else
			single = {half[15], expOut, frac, 13'd0};
	end

endmodule

/* hdl/singleToHalf.sv */
// single to half narrowing
`timescale 1ns/1ps

module singleToHalf import simdPkg::*;
(
	input spFloat single,
	output hpFloat half
);

	logic [7:0] expIn;
	logic [22:0] frac;
	logic isNan;
	logic isInf;
	logic signed [9:0] expOut;

	assign expIn = single[30:23];
	assign frac = single[22:0];
	assign isNan = (expIn == 8'hFF) && (frac != 23'd0);
	assign isInf = (expIn == 8'hFF) && (frac == 23'd0);

	// rebias from 127 to 15, may leave the half range either way
	assign expOut = $signed({2'b00, expIn}) - 10'sd112;

	always_comb
	begin
		if (isNan)
			half = hpQuietNan;
		else if (isInf || expOut >= 10'sd31)
			// too large for half, saturate
			half = {single[31], 5'h1F, 10'd0};
		else if (expIn == 8'd0 || expOut <= 10'sd0)
			// below the normal half range, flush
			half = {single[31], 15'd0};
		else
			// mantissa is simply truncated to ten bits
			half = {single[31], expOut[4:0], frac[22:13]};
	end

endmodule

/* hdl/fpAddLane.sv */
// single-precision add lane
`timescale 1ns/1ps

module fpAddLane import simdPkg::*;
(
	input logic clock,
	input logic rst,
	fpLaneIf.lane io
);

	// stage one operands
	logic [7:0] expA;
	logic [7:0] expB;
	logic [23:0] manA;
	logic [23:0] manB;
	logic signA;
	logic signB;
	logic nanIn;
	logic infA;
	logic infB;
	logic swap;
	logic [7:0] expDiff;
	logic [23:0] alignSmall;
	logic specNext;
	spFloat specValNext;

	// stage one registers
	logic s1Special;
	spFloat s1SpecVal;
	logic s1Sign;
	logic [7:0] s1Exp;
	logic [23:0] s1ManBig;
	logic [23:0] s1ManSmall;
	logic s1DoSub;

	// stage two
	logic [24:0] sum;
	logic [4:0] lz;
	logic [23:0] normMan;
	logic signed [9:0] normExp;
	spFloat resNext;

	// position of the leading one, counted from bit 23
	function automatic logic [4:0] countLz(input logic [23:0] v);
		logic [4:0] cnt;
		cnt = 5'd24;
		for (int i = 0; i < 24; i++)
		begin
			if (v[i])
				cnt = 5'(23 - i);
		end
		return cnt;
	endfunction

	assign expA = io.srcA[30:23];
	assign expB = io.srcB[30:23];
	assign signA = io.srcA[31];
	// subtract is add with b negated
	assign signB = io.srcB[31] ^ io.isSub;

	// flush to zero drops the hidden bit and the fraction
	assign manA = (expA == 8'd0) ? 24'd0 : {1'b1, io.srcA[22:0]};
	assign manB = (expB == 8'd0) ? 24'd0 : {1'b1, io.srcB[22:0]};

	assign nanIn = ((expA == 8'hFF) && (io.srcA[22:0] != 23'd0)) ||
		((expB == 8'hFF) && (io.srcB[22:0] != 23'd0));
	assign infA = (expA == 8'hFF) && (io.srcA[22:0] == 23'd0);
	assign infB = (expB == 8'hFF) && (io.srcB[22:0] == 23'd0);

	// larger magnitude goes first, the smaller one is shifted right
	assign swap = {expB, manB} > {expA, manA};
	assign expDiff = swap ? (expB - expA) : (expA - expB);
	assign alignSmall = (swap ? manA : manB) >> expDiff;

	always_comb
	begin
		specNext = 1'b1;
		specValNext = spQuietNan;
		if (nanIn || (infA && infB && (signA != signB)))
			specValNext = spQuietNan;
		else if (infA)
			specValNext = {signA, 8'hFF, 23'd0};
		else if (infB)
			specValNext = {signB, 8'hFF, 23'd0};
		else
			specNext = 1'b0;
	end

	// big operand never falls below the small one, so no negative sums
	assign sum = s1DoSub ? ({1'b0, s1ManBig} - {1'b0, s1ManSmall}) :
		({1'b0, s1ManBig} + {1'b0, s1ManSmall});
	assign lz = countLz(sum[23:0]);

	always_comb
	begin
		normMan = sum[23:0] << lz;
		normExp = $signed({2'b00, s1Exp}) - $signed({5'd0, lz});
		if (sum[24])
		begin
			// carry out, the low bit is truncated
			normMan = sum[24:1];
			normExp = $signed({2'b00, s1Exp}) + 10'sd1;
		end

		if (s1Special)
			resNext = s1SpecVal;
		else if (sum == 25'd0)
			resNext = '0;
		else if (normExp >= 10'sd255)
			resNext = {s1Sign, 8'hFF, 23'd0};
		else if (normExp <= 10'sd0)
			resNext = {s1Sign, 31'd0};
		else
			resNext = {s1Sign, normExp[7:0], normMan[22:0]};
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			s1Special <= 1'b0;
			s1SpecVal <= '0;
			s1Sign <= 1'b0;
			s1Exp <= '0;
			s1ManBig <= '0;
			s1ManSmall <= '0;
			s1DoSub <= 1'b0;
			io.result <= '0;
		end
		else if (!io.hold)
		begin
			s1Special <= specNext;
			s1SpecVal <= specValNext;
			s1Sign <= swap ? signB : signA;
			s1Exp <= swap ? expB : expA;
			s1ManBig <= swap ? manB : manA;
			s1ManSmall <= alignSmall;
			s1DoSub <= signA ^ signB;
			io.result <= resNext;
		end
	end

endmodule

/* hdl/fpMulLane.sv */
// single-precision multiply lane
`timescale 1ns/1ps

module fpMulLane import simdPkg::*;
(
	input logic clock,
	input logic rst,
	fpLaneIf.lane io
);

	logic [7:0] expA;
	logic [7:0] expB;
	logic signOut;
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	logic zeroA;
	logic zeroB;
	logic specNext;
	spFloat specValNext;

	logic s1Special;
	spFloat s1SpecVal;
	logic s1Sign;
	logic signed [9:0] s1Exp;
	logic [47:0] s1Prod;

	logic signed [9:0] normExp;
	logic [22:0] normMan;
	spFloat resNext;

	assign expA = io.srcA[30:23];
	assign expB = io.srcB[30:23];
	assign signOut = io.srcA[31] ^ io.srcB[31];

	assign nanA = (expA == 8'hFF) && (io.srcA[22:0] != 23'd0);
	assign nanB = (expB == 8'hFF) && (io.srcB[22:0] != 23'd0);
	assign infA = (expA == 8'hFF) && (io.srcA[22:0] == 23'd0);
	assign infB = (expB == 8'hFF) && (io.srcB[22:0] == 23'd0);
	// subnormal inputs count as zero
	assign zeroA = expA == 8'd0;
	assign zeroB = expB == 8'd0;

	always_comb
	begin
		specNext = 1'b1;
		specValNext = spQuietNan;
		if (nanA || nanB || (infA && zeroB) || (infB && zeroA))
			specValNext = spQuietNan;
		else if (infA || infB)
			specValNext = {signOut, 8'hFF, 23'd0};
		else if (zeroA || zeroB)
			specValNext = {signOut, 31'd0};
		else
			specNext = 1'b0;
	end

	// product of two normal mantissas is in [1, 4), one shift at most
	assign normExp = s1Prod[47] ? (s1Exp + 10'sd1) : s1Exp;
	assign normMan = s1Prod[47] ? s1Prod[46:24] : s1Prod[45:23];

	always_comb
	begin
		if (s1Special)
			resNext = s1SpecVal;
		else if (normExp >= 10'sd255)
			resNext = {s1Sign, 8'hFF, 23'd0};
		else if (normExp <= 10'sd0)
			resNext = {s1Sign, 31'd0};
		else
			resNext = {s1Sign, normExp[7:0], normMan};
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			s1Special <= 1'b0;
			s1SpecVal <= '0;
			s1Sign <= 1'b0;
			s1Exp <= '0;
			s1Prod <= '0;
			io.result <= '0;
		end
		else if (!io.hold)
		begin
			s1Special <= specNext;
			s1SpecVal <= specValNext;
			s1Sign <= signOut;
			s1Exp <= $signed({2'b00, expA}) + $signed({2'b00, expB}) - 10'sd127;
			s1Prod <= {1'b1, io.srcA[22:0]} * {1'b1, io.srcB[22:0]};
			io.result <= resNext;
		end
	end

endmodule

/* hdl/simdVec4Unit.sv */
// four-wide SIMD float execute unit
`timescale 1ns/1ps

module simdVec4Unit import simdPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input cmdWord cmdA,
	input cmdWord cmdB,
	input ixtWord ixtA,
	input ixtWord ixtB,
	input regWord rsA,
	input regWord rsB,
	input regWord rtA,
	input regWord rtB,
	output regWord rnA,
	output regWord rnB,
	output logic resultLive
);

	logic vecA;
	logic vecB;
	logic useLaneB;
	logic issueLive;
	ixtWord ixtSel;
	regWord rsSel;
	regWord rtSel;
	fmtCode issueFmt;
	opCode issueOp;
	logic issueHalf;
	logic issueSub;
	logic issueMul;

	// single format always spans both A and B sources
	logic [127:0] rsPair;
	logic [127:0] rtPair;

	logic live1;
	logic live2;
	logic mul1;
	logic mul2;
	fmtCode fmt1;
	fmtCode fmt2;

	spFloat laneRes [4];
	hpFloat narrowed [4];
	regWord halfVec;

	fpLaneIf addIf [4] ();
	fpLaneIf mulIf [4] ();

	// B is claimed only when A carries no vector command
	assign vecA = cmdA[5:0] == ucmdFpuVec4;
	assign vecB = cmdB[5:0] == ucmdFpuVec4;
	assign useLaneB = vecB && !vecA;
	assign issueLive = vecA || vecB;

	assign ixtSel = useLaneB ? ixtB : ixtA;
	assign rsSel = useLaneB ? rsB : rsA;
	assign rtSel = useLaneB ? rtB : rtA;
	assign rsPair = {rsB, rsA};
	assign rtPair = {rtB, rtA};

	assign issueFmt = ixtSel[5:4];
	assign issueOp = ixtSel[3:0];
	assign issueHalf = issueFmt == ixtFmtHalf;

	always_comb
	begin
		issueSub = 1'b0;
		issueMul = 1'b0;
		case (issueOp)
			ixtOpAdd: issueSub = 1'b0;
			ixtOpSub: issueSub = 1'b1;
			ixtOpMul: issueMul = 1'b1;
			// unknown codes run as add
			default: issueSub = 1'b0;
		endcase
	end

	// follows each command down the two lane stages
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			live1 <= 1'b0;
			live2 <= 1'b0;
			mul1 <= 1'b0;
			mul2 <= 1'b0;
			fmt1 <= ixtFmtSingle;
			fmt2 <= ixtFmtSingle;
		end
		else if (!hold)
		begin
			live1 <= issueLive;
			live2 <= live1;
			mul1 <= issueMul;
			mul2 <= mul1;
			fmt1 <= issueFmt;
			fmt2 <= fmt1;
		end
	end

	assign resultLive = live2;

	for (genvar i = 0; i < 4; i++)
	begin : gElem
		spFloat wideRs;
		spFloat wideRt;
		spFloat srcRs;
		spFloat srcRt;

		halfToSingle rsWiden (.half(rsSel[16*i +: 16]), .single(wideRs));
		halfToSingle rtWiden (.half(rtSel[16*i +: 16]), .single(wideRt));

		// elements a/b from the A sources, c/d from the B sources
		assign srcRs = issueHalf ? wideRs : rsPair[32*i +: 32];
		assign srcRt = issueHalf ? wideRt : rtPair[32*i +: 32];

		assign addIf[i].hold = hold;
		assign addIf[i].srcA = srcRs;
		assign addIf[i].srcB = srcRt;
		assign addIf[i].isSub = issueSub;

		assign mulIf[i].hold = hold;
		assign mulIf[i].srcA = srcRs;
		assign mulIf[i].srcB = srcRt;
		assign mulIf[i].isSub = issueSub;

		fpAddLane addLane (.clock(clock), .rst(rst), .io(addIf[i]));
		fpMulLane mulLane (.clock(clock), .rst(rst), .io(mulIf[i]));

		assign laneRes[i] = mul2 ? mulIf[i].result : addIf[i].result;

		singleToHalf resNarrow (.single(laneRes[i]), .half(narrowed[i]));
	end

	assign halfVec = {narrowed[3], narrowed[2], narrowed[1], narrowed[0]};

	always_comb
	begin
		case (fmt2)
			ixtFmtHalf:
			begin
				// half results go out the same on both ports
				rnA = halfVec;
				rnB = halfVec;
			end
			ixtFmtSingle:
			begin
				rnA = {laneRes[1], laneRes[0]};
				rnB = {laneRes[3], laneRes[2]};
			end
			default:
			begin
				// reserved formats pack as single
				rnA = {laneRes[1], laneRes[0]};
				rnB = {laneRes[3], laneRes[2]};
			end
		endcase
	end

endmodule

/* verif/simdVec4_assertions.sv */
// SIMD unit timing assertions
`timescale 1ns/1ps

module simdVec4_assertions import simdPkg::*;
(
	input logic clock,
	input logic rst,
	input logic hold,
	input cmdWord cmdA,
	input cmdWord cmdB,
	input regWord rnA,
	input regWord rnB,
	input logic resultLive
);

	logic claimed;
	// claim status at the most recent advancing edge
	logic claimedPrev;
	int failCount = 0;

	assign claimed = (cmdA[5:0] == ucmdFpuVec4) || (cmdB[5:0] == ucmdFpuVec4);

	always_ff @(posedge clock)
	begin
		if (rst)
			claimedPrev <= 1'b0;
		else if (!hold)
			claimedPrev <= claimed;
	end

	resetClear: assert property (@(posedge clock) $fell(rst) |-> !resultLive)
	else
	begin
		$error("resultLive high in the first cycle after reset");
		failCount++;
	end

	// second advancing edge after the claim brings the result out
	issueToResult: assert property (@(posedge clock) disable iff (rst)
		(!hold && claimedPrev) |=> resultLive)
	else
	begin
		$error("claimed command did not reach resultLive after two advancing edges");
		failCount++;
	end

	frozenOnHold: assert property (@(posedge clock) disable iff (rst)
		hold |=> ($stable(rnA) && $stable(rnB) && $stable(resultLive)))
	else
	begin
		$error("outputs changed across a held edge");
		failCount++;
	end

	noStrayResult: assert property (@(posedge clock) disable iff (rst)
		(!hold && !claimedPrev) |=> !resultLive)
	else
	begin
		$error("resultLive high without a claimed command two advancing edges earlier");
		failCount++;
	end

endmodule

bind simdVec4Unit simdVec4_assertions timingChecks (.*);

/* verif/simdVec4Tb.sv */
// SIMD unit testbench
`timescale 1ns/1ps

module simdVec4Tb import simdPkg::*;
();

	localparam int cycleLimit = 400;
	localparam cmdWord idleCmd = 9'h011;

	logic clock;
	logic rst;
	logic hold;
	cmdWord cmdA;
	cmdWord cmdB;
	ixtWord ixtA;
	ixtWord ixtB;
	regWord rsA;
	regWord rsB;
	regWord rtA;
	regWord rtB;
	regWord rnA;
	regWord rnB;
	logic resultLive;

	// operands of the next command, one pair per element
	int opX [4];
	int opY [4];

	regWord expRnA [$];
	regWord expRnB [$];
	string expName [$];

	int errors = 0;
	int cycles = 0;

	simdVec4Unit i_simdVec4Unit (.*);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	function automatic int msbIndex(input int mag);
		int pos;
		pos = 0;
		for (int i = 0; i < 31; i++)
		begin
			if (mag[i])
				pos = i;
		end
		return pos;
	endfunction

	// exact IEEE encodings of small integers
	function automatic spFloat singleOf(input int v, input bit negZero);
		int mag;
		int pos;
		mag = (v < 0) ? -v : v;
		if (mag == 0)
			return {negZero, 31'd0};
		pos = msbIndex(mag);
		return {v < 0, 8'(127 + pos), 23'(mag << (23 - pos))};
	endfunction

	function automatic hpFloat halfOf(input int v, input bit negZero);
		int mag;
		int pos;
		int frac;
		mag = (v < 0) ? -v : v;
		if (mag == 0)
			return {negZero, 15'd0};
		pos = msbIndex(mag);
		frac = (pos > 10) ? (mag >> (pos - 10)) : (mag << (10 - pos));
		return {v < 0, 5'(15 + pos), 10'(frac)};
	endfunction

	task automatic setOps(input int x0, x1, x2, x3, y0, y1, y2, y3);
		opX = '{x0, x1, x2, x3};
		opY = '{y0, y1, y2, y3};
	endtask

	task automatic randomOps(input int range);
		for (int k = 0; k < 4; k++)
		begin
			opX[k] = int'($urandom_range(2 * range)) - range;
			opY[k] = int'($urandom_range(2 * range)) - range;
		end
	endtask

	task automatic idleCycles(input int n, input logic holdLevel);
		cmdA = idleCmd;
		cmdB = idleCmd;
		hold = holdLevel;
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	// lane 0 is A only, 1 is B only, 2 is both
	task automatic issueCmd(input int lane, input fmtCode fmt, input opCode op, input string name);
		cmdWord vecCmd;
		ixtWord ixt;
		regWord rsHalf;
		regWord rtHalf;
		int res;
		bit negZero;
		spFloat sRes [4];
		hpFloat hRes [4];
		vecCmd = {3'($urandom), ucmdFpuVec4};
		ixt = {3'b000, fmt, op};
		for (int k = 0; k < 4; k++)
		begin
			case (op)
				ixtOpSub: res = opX[k] - opY[k];
				ixtOpMul: res = opX[k] * opY[k];
				default: res = opX[k] + opY[k];
			endcase
			// a zero product keeps the sign of the operands
			negZero = (op == ixtOpMul) && (res == 0) && ((opX[k] < 0) != (opY[k] < 0));
			sRes[k] = singleOf(res, negZero);
			hRes[k] = halfOf(res, negZero);
			rsHalf[16*k +: 16] = halfOf(opX[k], 1'b0);
			rtHalf[16*k +: 16] = halfOf(opY[k], 1'b0);
		end
		cmdA = (lane == 1) ? idleCmd : vecCmd;
		cmdB = (lane == 0) ? idleCmd : vecCmd;
		ixtA = (lane == 1) ? 9'($urandom) : ixt;
		ixtB = (lane == 2) ? (ixt ^ 9'h013) : ((lane == 1) ? ixt : 9'($urandom));
		rsA = {$urandom, $urandom};
		rsB = {$urandom, $urandom};
		rtA = {$urandom, $urandom};
		rtB = {$urandom, $urandom};
		if (fmt == ixtFmtHalf)
		begin
			if (lane == 1)
			begin
				rsB = rsHalf;
				rtB = rtHalf;
			end
			else
			begin
				rsA = rsHalf;
				rtA = rtHalf;
			end
			expRnA.push_back({hRes[3], hRes[2], hRes[1], hRes[0]});
			expRnB.push_back({hRes[3], hRes[2], hRes[1], hRes[0]});
		end
		else
		begin
			// single format always spans both lanes' sources
			rsA = {singleOf(opX[1], 1'b0), singleOf(opX[0], 1'b0)};
			rsB = {singleOf(opX[3], 1'b0), singleOf(opX[2], 1'b0)};
			rtA = {singleOf(opY[1], 1'b0), singleOf(opY[0], 1'b0)};
			rtB = {singleOf(opY[3], 1'b0), singleOf(opY[2], 1'b0)};
			expRnA.push_back({sRes[1], sRes[0]});
			expRnB.push_back({sRes[3], sRes[2]});
		end
		expName.push_back(name);
		hold = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic checkValue(input string test, input string port, input regWord want,
		input regWord got);
		if (got !== want)
		begin
			$display("CHECK FAILED %s %s expected %h actual %h", test, port, want, got);
			errors++;
		end
	endtask

	// a result retires at the next edge when hold is low
	always @(negedge clock)
	begin
		if (!rst && resultLive && !hold)
		begin
			if (expRnA.size() == 0)
			begin
				$display("resultLive high with no command outstanding at %0t", $time);
				errors++;
			end
			else
			begin
				checkValue(expName[0], "rnA", expRnA.pop_front(), rnA);
				checkValue(expName.pop_front(), "rnB", expRnB.pop_front(), rnB);
			end
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout after %0d cycles, %0d results outstanding, %0d errors",
				cycles, expRnA.size(), errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		fmtCode fmt;
		opCode op;
		int lane;
		int assertFails;
		void'($urandom(32'h6860_de6d));
		rst = 1'b1;
		hold = 1'b0;
		cmdA = idleCmd;
		cmdB = idleCmd;
		ixtA = '0;
		ixtB = '0;
		rsA = '0;
		rsB = '0;
		rtA = '0;
		rtB = '0;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		idleCycles(3, 1'b0);

		setOps(3, -5, 17, 64, 2, 9, -17, -8);
		issueCmd(0, ixtFmtSingle, ixtOpAdd, "single add");
		issueCmd(0, ixtFmtSingle, ixtOpSub, "single sub");
		setOps(-64, 0, 13, -7, 64, -9, 11, -7);
		issueCmd(0, ixtFmtSingle, ixtOpMul, "single mul");

		setOps(1, -30, 64, 0, 5, 12, -64, -3);
		issueCmd(0, ixtFmtHalf, ixtOpAdd, "half add");
		setOps(-32, 7, 0, 19, 32, -6, -4, 21);
		issueCmd(0, ixtFmtHalf, ixtOpMul, "half mul");

		randomOps(32);
		issueCmd(1, ixtFmtHalf, ixtOpAdd, "lane B only");
		issueCmd(1, ixtFmtSingle, ixtOpSub, "lane B single");
		issueCmd(2, ixtFmtHalf, ixtOpMul, "both lanes");
		// extension fields look valid but no opcode matches
		ixtA = {3'b000, ixtFmtSingle, ixtOpAdd};
		ixtB = {3'b000, ixtFmtHalf, ixtOpMul};
		idleCycles(3, 1'b0);

		randomOps(64);
		issueCmd(0, ixtFmtSingle, ixtOpAdd, "hold first");
		issueCmd(0, ixtFmtHalf, ixtOpSub, "hold second");
		idleCycles(4, 1'b1);
		idleCycles(3, 1'b0);

		for (int n = 0; n < 150; n++)
		begin
			fmt = fmtCode'($urandom_range(1));
			op = opCode'($urandom_range(3));
			lane = $urandom_range(2);
			// half products above 2048 would not be exact
			randomOps(((op == ixtOpMul) && (fmt == ixtFmtHalf)) ? 32 : 64);
			issueCmd(lane, fmt, op, "random");
			if ($urandom_range(4) == 0)
				idleCycles(1, 1'b1);
		end

		while (expRnA.size() != 0)
			idleCycles(1, 1'b0);
		idleCycles(2, 1'b0);

		assertFails = i_simdVec4Unit.timingChecks.failCount;
		$display("value errors: %0d, assertion failures: %0d", errors, assertFails);
		if (errors == 0 && assertFails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* project.f */
hdl/simdPkg.sv
hdl/fpLaneIf.sv
hdl/halfToSingle.sv
hdl/singleToHalf.sv
hdl/fpAddLane.sv
hdl/fpMulLane.sv
hdl/simdVec4Unit.sv
verif/simdVec4_assertions.sv
verif/simdVec4Tb.sv
